//--- logic/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// data and address width.
`define WORD_W 32

// architectural register count.
`define REG_COUNT 32

// bits needed to index a register.
`define REG_W 5

`endif

//--- logic/cpu_types_pkg.sv
`include "cpu_config.svh"

package cpu_types_pkg;

    typedef logic [`WORD_W-1:0] word_t;
    typedef logic [`REG_W-1:0]  regbits_t;

    typedef enum logic [1:0] {
        MEM_NONE,
        LOAD,
        STORE
    } mem_type_t;

    // passb forwards operand b for lui.
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASSB
    } alu_op_t;

    // rv32i major opcodes kept by this slice.
    typedef enum logic [6:0] {
        OP_IMM   = 7'b0010011,
        OP_REG   = 7'b0110011,
        OP_LUI   = 7'b0110111,
        OP_LOAD  = 7'b0000011,
        OP_STORE = 7'b0100011
    } opcode_t;

endpackage

//--- logic/scalar_decode.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module scalar_decode (
    input  cpu_types_pkg::word_t     instr,
    input  logic                     instr_valid,
    output cpu_types_pkg::regbits_t  rs1,
    output cpu_types_pkg::regbits_t  rs2,
    output cpu_types_pkg::regbits_t  rd,
    output cpu_types_pkg::word_t     imm,
    output cpu_types_pkg::alu_op_t   alu_op,
    output logic                     use_imm,
    output cpu_types_pkg::mem_type_t mem_type,
    output logic                     reg_write,
    output logic                     illegal
);

    import cpu_types_pkg::*;

    opcode_t    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = opcode_t'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rd  = instr[11:7];

    always_comb begin
        imm       = '0;
        alu_op    = ALU_ADD;
        use_imm   = 1'b0;
        mem_type  = MEM_NONE;
        reg_write = 1'b0;
        illegal   = 1'b0;
        if (instr_valid) begin
            case (opcode)
                OP_IMM: begin
                    imm       = {{(`WORD_W-12){instr[31]}}, instr[31:20]};
                    use_imm   = 1'b1;
                    reg_write = 1'b1;
                    case (funct3)
                        3'b000:  alu_op = ALU_ADD;
                        3'b010:  alu_op = ALU_SLT;
                        3'b100:  alu_op = ALU_XOR;
                        3'b110:  alu_op = ALU_OR;
                        3'b111:  alu_op = ALU_AND;
                        default: begin
                            reg_write = 1'b0;
                            illegal   = 1'b1;
                        end
                    endcase
                end
                OP_REG: begin
                    reg_write = 1'b1;
                    case ({funct7, funct3})
                        {7'b0000000, 3'b000}: alu_op = ALU_ADD;
                        {7'b0100000, 3'b000}: alu_op = ALU_SUB;
                        {7'b0000000, 3'b010}: alu_op = ALU_SLT;
                        {7'b0000000, 3'b100}: alu_op = ALU_XOR;
                        {7'b0000000, 3'b110}: alu_op = ALU_OR;
                        {7'b0000000, 3'b111}: alu_op = ALU_AND;
                        default: begin
                            reg_write = 1'b0;
                            illegal   = 1'b1;
                        end
                    endcase
                end
                OP_LUI: begin
                    imm       = {instr[31:12], 12'b0};
                    alu_op    = ALU_PASSB;
                    use_imm   = 1'b1;
                    reg_write = 1'b1;
                end
                OP_LOAD: begin
                    imm = {{(`WORD_W-12){instr[31]}}, instr[31:20]};
                    // word accesses only.
                    if (funct3 == 3'b010) begin
                        mem_type  = LOAD;
                        reg_write = 1'b1;
                    end else begin
                        illegal = 1'b1;
                    end
                end
                OP_STORE: begin
                    imm = {{(`WORD_W-12){instr[31]}}, instr[31:25], instr[11:7]};
                    if (funct3 == 3'b010) begin
                        mem_type = STORE;
                    end else begin
                        illegal = 1'b1;
                    end
                end
                default: illegal = 1'b1;
            endcase
        end
    end

endmodule

//--- logic/scalar_regfile.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module scalar_regfile (
    input  logic                    CLK,
    input  logic                    nRST,
    input  cpu_types_pkg::regbits_t rs1,
    input  cpu_types_pkg::regbits_t rs2,
    input  logic                    wen,
    input  cpu_types_pkg::regbits_t wsel,
    input  cpu_types_pkg::word_t    wdata,
    output cpu_types_pkg::word_t    rdata1,
    output cpu_types_pkg::word_t    rdata2
);

    import cpu_types_pkg::*;

    word_t regs [`REG_COUNT];

    // x0 is cleared on reset and never written, so it reads as zero.
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (wsel != '0)) begin
            regs[wsel] <= wdata;
        end
    end

    assign rdata1 = regs[rs1];
    assign rdata2 = regs[rs2];

endmodule

//--- logic/fu_scalar_alu.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module fu_scalar_alu (
    input  cpu_types_pkg::alu_op_t alu_op,
    input  cpu_types_pkg::word_t   rdata1,
    input  cpu_types_pkg::word_t   rdata2,
    input  cpu_types_pkg::word_t   imm,
    input  logic                   use_imm,
    output cpu_types_pkg::word_t   alu_result
);

    import cpu_types_pkg::*;

    word_t opa;
    word_t opb;
    logic  less;

    assign opa = rdata1;
    assign opb = use_imm ? imm : rdata2;

    // signed compare for slt and slti.
    assign less = $signed(opa) < $signed(opb);

    always_comb begin
        case (alu_op)
            ALU_ADD:   alu_result = opa + opb;
            ALU_SUB:   alu_result = opa - opb;
            ALU_AND:   alu_result = opa & opb;
            ALU_OR:    alu_result = opa | opb;
            ALU_XOR:   alu_result = opa ^ opb;
            ALU_SLT:   alu_result = {{(`WORD_W-1){1'b0}}, less};
            ALU_PASSB: alu_result = opb;
            default:   alu_result = '0;
        endcase
    end

endmodule

//--- logic/fu_scalar_ls.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module fu_scalar_ls (
    input  logic                     CLK,
    input  logic                     nRST,
    input  cpu_types_pkg::mem_type_t mem_type,
    input  cpu_types_pkg::word_t     rdata1,
    input  cpu_types_pkg::word_t     rdata2,
    input  cpu_types_pkg::word_t     imm,
    input  logic                     dhit_in,
    input  cpu_types_pkg::word_t     dmem_in,
    output cpu_types_pkg::word_t     dmemaddr,
    output cpu_types_pkg::word_t     dmemstore,
    output logic                     dmemREN,
    output logic                     dmemWEN,
    output logic                     dhit,
    output logic                     busy,
    output cpu_types_pkg::word_t     dmemload
);

    import cpu_types_pkg::*;

    typedef enum logic {
        IDLE,
        LATCHED
    } state_t;

    state_t state;
    state_t next_state;

    word_t addr;
    word_t latched_addr;
    word_t latched_store;
    logic  latched_ren;
    logic  latched_wen;
    logic  read;
    logic  write;

    assign addr  = rdata1 + imm;
    assign read  = (mem_type == LOAD);
    assign write = (mem_type == STORE);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state       <= IDLE;
            latched_ren <= 1'b0;
            latched_wen <= 1'b0;
        end else begin
            state <= next_state;
            if (state == IDLE) begin
                latched_ren <= read;
                latched_wen <= write;
            end
        end
    end

    // request payload captured at issue.
    always_ff @(posedge CLK) begin
        if (state == IDLE && (read || write)) begin
            latched_addr  <= addr;
            latched_store <= write ? rdata2 : '0;
        end
    end

    always_comb begin
        next_state = state;
        dmemaddr   = '0;
        dmemstore  = '0;
        dmemREN    = 1'b0;
        dmemWEN    = 1'b0;
        dhit       = 1'b0;
        dmemload   = '0;
        case (state)
            IDLE: begin
                if (write) begin
                    dmemaddr   = addr;
                    dmemstore  = rdata2;
                    dmemWEN    = 1'b1;
                    next_state = LATCHED;
                end else if (read) begin
                    dmemaddr   = addr;
                    dmemREN    = 1'b1;
                    next_state = LATCHED;
                end
            end
            LATCHED: begin
                dmemaddr  = latched_addr;
                dmemstore = latched_store;
                dmemREN   = latched_ren;
                dmemWEN   = latched_wen;
                if (dhit_in) begin
                    dmemREN    = 1'b0;
                    dmemWEN    = 1'b0;
                    dhit       = 1'b1;
                    next_state = IDLE;
                    if (latched_ren) begin
                        dmemload = dmem_in;
                    end
                end
            end
            default: next_state = IDLE;
        endcase
    end

    // falls in the hit cycle so the held instruction retires there.
    assign busy = (state == LATCHED) && !dhit_in;

endmodule

//--- logic/scalar_writeback.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module scalar_writeback (
    input  logic                     reg_write,
    input  logic                     issue,
    input  cpu_types_pkg::mem_type_t mem_type,
    input  cpu_types_pkg::regbits_t  rd,
    input  cpu_types_pkg::word_t     alu_result,
    input  logic                     dhit,
    input  cpu_types_pkg::word_t     dmemload,
    output logic                     wen,
    output cpu_types_pkg::regbits_t  wsel,
    output cpu_types_pkg::word_t     wdata,
    output logic                     wb_valid,
    output cpu_types_pkg::regbits_t  wb_rd,
    output cpu_types_pkg::word_t     wb_data
);

    import cpu_types_pkg::*;

    logic alu_done;
    logic load_done;
    logic rd_nonzero;

    // alu results retire at issue, loads at the memory hit.
    assign alu_done   = issue && (mem_type == MEM_NONE);
    assign load_done  = dhit && (mem_type == LOAD);
    assign rd_nonzero = (rd != `REG_W'(0));

    assign wen   = reg_write && rd_nonzero && (alu_done || load_done);
    assign wsel  = rd;
    assign wdata = (mem_type == LOAD) ? dmemload : alu_result;

    assign wb_valid = wen;
    assign wb_rd    = wen ? rd : '0;
    assign wb_data  = wen ? wdata : '0;

endmodule

//--- logic/scalar_exec_top.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module scalar_exec_top (
    input  logic                    CLK,
    input  logic                    nRST,
    input  cpu_types_pkg::word_t    instr,
    input  logic                    instr_valid,
    input  logic                    dhit_in,
    input  cpu_types_pkg::word_t    dmem_in,
    output logic                    busy,
    output cpu_types_pkg::word_t    dmemaddr,
    output cpu_types_pkg::word_t    dmemstore,
    output logic                    dmemREN,
    output logic                    dmemWEN,
    output logic                    wb_valid,
    output cpu_types_pkg::regbits_t wb_rd,
    output cpu_types_pkg::word_t    wb_data,
    output logic                    illegal
);

    import cpu_types_pkg::*;

    regbits_t  rs1;
    regbits_t  rs2;
    regbits_t  rd;
    word_t     imm;
    alu_op_t   alu_op;
    logic      use_imm;
    mem_type_t mem_type;
    logic      reg_write;
    word_t     rdata1;
    word_t     rdata2;
    word_t     alu_result;
    logic      dhit;
    word_t     dmemload;
    logic      wen;
    regbits_t  wsel;
    word_t     wdata;
    logic      issue;

    assign issue = instr_valid && !busy;

    scalar_decode scalar_decode_inst (
        .instr       (instr),
        .instr_valid (instr_valid),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd          (rd),
        .imm         (imm),
        .alu_op      (alu_op),
        .use_imm     (use_imm),
        .mem_type    (mem_type),
        .reg_write   (reg_write),
        .illegal     (illegal)
    );

    scalar_regfile scalar_regfile_inst (
        .CLK    (CLK),
        .nRST   (nRST),
        .rs1    (rs1),
        .rs2    (rs2),
        .wen    (wen),
        .wsel   (wsel),
        .wdata  (wdata),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    fu_scalar_alu fu_scalar_alu_inst (
        .alu_op     (alu_op),
        .rdata1     (rdata1),
        .rdata2     (rdata2),
        .imm        (imm),
        .use_imm    (use_imm),
        .alu_result (alu_result)
    );

    fu_scalar_ls fu_scalar_ls_inst (
        .CLK       (CLK),
        .nRST      (nRST),
        .mem_type  (mem_type),
        .rdata1    (rdata1),
        .rdata2    (rdata2),
        .imm       (imm),
        .dhit_in   (dhit_in),
        .dmem_in   (dmem_in),
        .dmemaddr  (dmemaddr),
        .dmemstore (dmemstore),
        .dmemREN   (dmemREN),
        .dmemWEN   (dmemWEN),
        .dhit      (dhit),
        .busy      (busy),
        .dmemload  (dmemload)
    );

    scalar_writeback scalar_writeback_inst (
        .reg_write  (reg_write),
        .issue      (issue),
        .mem_type   (mem_type),
        .rd         (rd),
        .alu_result (alu_result),
        .dhit       (dhit),
        .dmemload   (dmemload),
        .wen        (wen),
        .wsel       (wsel),
        .wdata      (wdata),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data)
    );

endmodule

//--- test/scalar_exec_tests.svh
`ifndef SCALAR_EXEC_TESTS_SVH
`define SCALAR_EXEC_TESTS_SVH

// rv32i funct3 meaning for the kept alu operations.
function automatic word_t alu_ref(logic [2:0] f3, logic sub, word_t a, word_t b);
    case (f3)
        3'b000:  return sub ? a - b : a + b;
        3'b010:  return word_t'($signed(a) < $signed(b));
        3'b100:  return a ^ b;
        3'b110:  return a | b;
        default: return a & b;
    endcase
endfunction

task automatic issue_alu(string test, word_t word, int rd, word_t expected);
    @(negedge CLK);
    instr       = word;
    instr_valid = 1'b1;
    @(posedge CLK);
    check_word(test, "wb_valid", word_t'(rd != 0), word_t'(wb_valid));
    check_word(test, "side effects", '0, word_t'({dmemREN, dmemWEN, illegal, busy}));
    check_word(test, "idle dmemaddr dmemstore", '0, dmemaddr | dmemstore);
    if (rd != 0) begin
        check_word(test, "wb_rd", word_t'(rd), word_t'(wb_rd));
        check_word(test, "wb_data", expected, wb_data);
        shadow[rd] = expected;
    end
    @(negedge CLK);
    instr_valid = 1'b0;
endtask

task automatic imm_op(string test, logic [2:0] f3, int rd, int rs1, int imm);
    issue_alu(test, {12'(imm), 5'(rs1), f3, 5'(rd), OP_IMM}, rd,
              alu_ref(f3, 1'b0, shadow[rs1], word_t'(imm)));
endtask

task automatic reg_op(string test, logic [2:0] f3, logic sub, int rd, int rs1, int rs2);
    issue_alu(test, {sub ? 7'b0100000 : 7'b0000000, 5'(rs2), 5'(rs1), f3, 5'(rd), OP_REG},
              rd, alu_ref(f3, sub, shadow[rs1], shadow[rs2]));
endtask

task automatic lui_op(string test, int rd, int imm20);
    issue_alu(test, {20'(imm20), 5'(rd), OP_LUI}, rd, {20'(imm20), 12'h000});
endtask

// rd_rs2 is the data register of a store or the target of a load.
task automatic mem_op(string test, logic store, int rd_rs2, int rs1, int imm);
    logic [11:0] im;
    word_t       addr;
    word_t       expected;
    logic        hit;
    int          cycles;
    im       = 12'(imm);
    addr     = shadow[rs1] + word_t'(imm);
    expected = store ? shadow[rd_rs2] : shadow_mem[addr[9:2]];
    @(negedge CLK);
    instr = store ? {im[11:5], 5'(rd_rs2), 5'(rs1), 3'b010, im[4:0], OP_STORE}
                  : {im, 5'(rs1), 3'b010, 5'(rd_rs2), OP_LOAD};
    instr_valid = 1'b1;
    hit    = 1'b0;
    cycles = 0;
    while (!hit) begin
        @(posedge CLK);
        hit = dhit_in;
        if (!hit) begin
            check_word(test, "dmemaddr", addr, dmemaddr);
            check_word(test, "REN WEN", word_t'(store ? 2'b01 : 2'b10),
                       word_t'({dmemREN, dmemWEN}));
            check_word(test, "busy", word_t'(cycles > 0), word_t'(busy));
            check_word(test, "early wb_valid", '0, word_t'(wb_valid));
            if (store) begin
                check_word(test, "dmemstore", expected, dmemstore);
            end
            cycles++;
            if (cycles > TIMEOUT) begin
                timed_out(test);
            end
        end
    end
    check_word(test, "busy and enables at hit", '0, word_t'({busy, dmemREN, dmemWEN}));
    check_word(test, "wb_valid", word_t'(!store && rd_rs2 != 0), word_t'(wb_valid));
    if (store) begin
        shadow_mem[addr[9:2]] = expected;
    end else if (rd_rs2 != 0) begin
        check_word(test, "wb_rd", word_t'(rd_rs2), word_t'(wb_rd));
        check_word(test, "wb_data", expected, wb_data);
        shadow[rd_rs2] = expected;
    end
    @(negedge CLK);
    instr_valid = 1'b0;
endtask

task automatic illegal_op(string test, word_t word);
    @(negedge CLK);
    instr       = word;
    instr_valid = 1'b1;
    @(posedge CLK);
    check_word(test, "illegal", 32'd1, word_t'(illegal));
    check_word(test, "side effects", '0, word_t'({wb_valid, dmemREN, dmemWEN, busy}));
    @(negedge CLK);
    instr_valid = 1'b0;
endtask

task automatic test_imm_ops();
    imm_op("addi", 3'b000, 1, 0, 100);
    imm_op("addi_neg", 3'b000, 2, 0, -5);
    imm_op("andi", 3'b111, 3, 1, 'h0F0);
    imm_op("ori", 3'b110, 4, 1, 'h700);
    imm_op("xori", 3'b100, 5, 2, 'h3FF);
    imm_op("slti", 3'b010, 6, 2, -1);
    imm_op("slti_false", 3'b010, 7, 1, 50);
    lui_op("lui", 8, 'hABCDE);
endtask

task automatic test_reg_ops();
    imm_op("setup_neg", 3'b000, 11, 0, -7);
    imm_op("setup_pos", 3'b000, 12, 0, 9);
    reg_op("add", 3'b000, 1'b0, 13, 11, 12);
    reg_op("sub", 3'b000, 1'b1, 14, 12, 11);
    reg_op("and", 3'b111, 1'b0, 15, 11, 12);
    reg_op("or", 3'b110, 1'b0, 16, 11, 12);
    reg_op("xor", 3'b100, 1'b0, 17, 11, 12);
    reg_op("slt", 3'b010, 1'b0, 18, 11, 12);
    reg_op("slt_false", 3'b010, 1'b0, 19, 12, 11);
    // x8 holds a negative upper immediate.
    reg_op("slt_sign", 3'b010, 1'b0, 20, 8, 1);
endtask

task automatic test_mem_ops();
    mem_op("sw", 1'b1, 8, 0, 64);
    mem_op("sw_offset", 1'b1, 13, 1, 12);
    mem_op("lw", 1'b0, 21, 0, 64);
    reg_op("lw_use", 3'b000, 1'b0, 22, 21, 0);
    mem_op("lw_offset", 1'b0, 23, 1, 12);
    mem_op("lw_unwritten", 1'b0, 24, 0, 512);
endtask

task automatic test_x0_illegal();
    imm_op("addi_x0", 3'b000, 0, 1, 55);
    mem_op("lw_x0", 1'b0, 0, 0, 64);
    reg_op("x0_read", 3'b000, 1'b0, 25, 0, 0);
    illegal_op("bad_opcode", 32'hFFFF_FFFF);
    illegal_op("bad_funct", {7'b0100000, 5'd2, 5'd1, 3'b111, 5'd1, OP_REG});
    // targets of the illegal words keep their values.
    imm_op("x31_kept", 3'b000, 26, 31, 0);
    imm_op("x1_kept", 3'b000, 27, 1, 0);
endtask

task automatic test_random_pairs();
    int base;
    int off;
    for (int i = 0; i < 8; i++) begin
        base = ({$random(seed)} % 128) * 4;
        off  = ({$random(seed)} % 128) * 4;
        imm_op("rand_base", 3'b000, 5, 0, base);
        lui_op("rand_hi", 6, {$random(seed)} % 'h100000);
        imm_op("rand_lo", 3'b000, 6, 6, $random(seed) % 2048);
        mem_op("rand_sw", 1'b1, 6, 5, off);
        mem_op("rand_lw", 1'b0, 7, 5, off);
    end
endtask

task automatic test_reset();
    @(negedge CLK);
    instr       = {12'd0, 5'd0, 3'b010, 5'd9, OP_LOAD};
    instr_valid = 1'b1;
    @(posedge CLK);
    // reset while the load is latched.
    @(negedge CLK);
    instr_valid = 1'b0;
    nRST        = 1'b0;
    repeat (2) @(posedge CLK);
    check_word("reset", "busy enables wb illegal", '0,
               word_t'({busy, dmemREN, dmemWEN, wb_valid, illegal}));
    @(negedge CLK);
    nRST = 1'b1;
    for (int i = 0; i < `REG_COUNT; i++) begin
        shadow[i] = '0;
    end
    imm_op("after_reset", 3'b000, 10, 1, 0);
    mem_op("lw_after_reset", 1'b0, 10, 0, 64);
endtask

`endif

//--- test/scalar_exec_tb.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module scalar_exec_tb;

    import cpu_types_pkg::*;

    localparam int TIMEOUT = 20;

    logic     CLK;
    logic     nRST;
    word_t    instr;
    logic     instr_valid;
    logic     dhit_in;
    word_t    dmem_in;
    logic     busy;
    word_t    dmemaddr;
    word_t    dmemstore;
    logic     dmemREN;
    logic     dmemWEN;
    logic     wb_valid;
    regbits_t wb_rd;
    word_t    wb_data;
    logic     illegal;

    integer seed = 34;
    int     value_errors = 0;
    int     protocol_errors = 0;
    int     timeouts = 0;
    word_t  mem [256];
    word_t  shadow_mem [256];
    word_t  shadow [`REG_COUNT];

    scalar_exec_top scalar_exec_top_inst (.*);

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    // contents of a word before any store.
    function automatic word_t fill_word(int index);
        return 32'hC0DE_0000 ^ word_t'(index * 4);
    endfunction

    task automatic check_word(string test, string what, word_t expected, word_t actual);
        assert (actual == expected) else begin
            value_errors++;
            $display("ERROR %s %s: expected %h, actual %h", test, what, expected, actual);
        end
    endtask

    task automatic finish_run();
        $display("errors: %0d value, %0d protocol, %0d timeout",
                 value_errors, protocol_errors, timeouts);
        if (value_errors + protocol_errors + timeouts == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    task automatic timed_out(string test);
        timeouts++;
        $display("%s: the data memory did not answer within %0d cycles", test, TIMEOUT);
        finish_run();
    endtask

    `include "scalar_exec_tests.svh"

    // data memory that answers 0 to 3 cycles after the request is latched.
    initial begin
        word_t req_addr;
        word_t req_store;
        logic  req_wen;
        int    delay;
        logic  aborted;
        dhit_in = 1'b0;
        dmem_in = '0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = fill_word(i);
        end
        forever begin
            @(posedge CLK);
            if (nRST && (dmemREN || dmemWEN)) begin
                req_addr  = dmemaddr;
                req_store = dmemstore;
                req_wen   = dmemWEN;
                delay     = {$random(seed)} % 4;
                aborted   = 1'b0;
                for (int i = 0; i < delay; i++) begin
                    @(posedge CLK);
                    aborted = aborted || !nRST;
                    assert (aborted || (dmemaddr == req_addr && dmemstore == req_store &&
                            dmemWEN == req_wen && dmemREN == !req_wen)) else begin
                        protocol_errors++;
                        $display("memory request changed while waiting at address %h", req_addr);
                    end
                end
                if (!aborted) begin
                    @(negedge CLK);
                    dhit_in = 1'b1;
                    if (req_wen) begin
                        mem[req_addr[9:2]] = req_store;
                    end else begin
                        dmem_in = mem[req_addr[9:2]];
                    end
                    @(negedge CLK);
                    dhit_in = 1'b0;
                    dmem_in = '0;
                end
            end
        end
    end

    initial begin
        nRST        = 1'b0;
        instr       = '0;
        instr_valid = 1'b0;
        for (int i = 0; i < `REG_COUNT; i++) begin
            shadow[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            shadow_mem[i] = fill_word(i);
        end
        repeat (2) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
        test_imm_ops();
        test_reg_ops();
        test_mem_ops();
        test_x0_illegal();
        test_random_pairs();
        test_reset();
        finish_run();
    end

endmodule

//--- build.f
+incdir+logic
+incdir+test
logic/cpu_types_pkg.sv
logic/scalar_decode.sv
logic/scalar_regfile.sv
logic/fu_scalar_alu.sv
logic/fu_scalar_ls.sv
logic/scalar_writeback.sv
logic/scalar_exec_top.sv
test/scalar_exec_tb.sv

//--- Makefile
# Verilator build and run for the scalar execution slice.

VERILATOR ?= verilator
TOP       ?= scalar_exec_tb
FLIST     ?= build.f
LOG       ?= sim.log
OBJ       ?= obj_dir
VFLAGS    ?=
PASS_MSG  := Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing --assert -f $(FLIST) --top-module $(TOP) \
		--Mdir $(OBJ) $(VFLAGS)

run: build
	./$(OBJ)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP) $(VFLAGS)

clean:
	rm -rf $(OBJ) $(LOG)
